/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dfx_secure_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "No errors" $(LOG); then \
		echo "simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* common/dfx_bus_pkg.sv */
// wishbone classic bus definitions and the policy register map
// request and response structs carry one word per access
package dfx_bus_pkg;

   // **********************************************************************
   // bus types
   // **********************************************************************
   // word address, 16 locations
   typedef logic [3:0]  wb_addr_t;
   // data word
   typedef logic [15:0] wb_data_t;

   // master to slave
   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      wb_addr_t adr;
      wb_data_t dat_w;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic     ack;
      wb_data_t dat_r;
   } wb_rsp_t;

   // **********************************************************************
   // register map
   // **********************************************************************
   // bits 3:0 policy, a write also pulses the update strobe
   localparam wb_addr_t reg_policy = 4'd0;
   // bit 0 early boot exit, sticky until reset
   localparam wb_addr_t reg_boot   = 4'd1;
   // bits 9:0 sideband override value
   localparam wb_addr_t reg_sb_ovr = 4'd2;
   // bits 3:0 oem policy strap
   localparam wb_addr_t reg_oem    = 4'd3;
   // read only, enables in 9:0 and captured policy in 15:12
   localparam wb_addr_t reg_status = 4'd4;

endpackage

/* common/dfx_policy_pkg.sv */
// debug security policy definitions
// widths, policy codes and the structs passed between the register
// slave and the policy plugin
package dfx_policy_pkg;

   // **********************************************************************
   // widths
   // **********************************************************************
   // one policy code, fixed by the chassis
   localparam int secure_width = 4;
   // number of secured debug features
   localparam int num_features = 8;
   // feature enables plus the two visa control bits
   localparam int group_width  = num_features + 2;
   // one matrix entry for every possible code
   localparam int num_policies = 1 << secure_width;
   localparam int matrix_width = num_policies * group_width;

   // **********************************************************************
   // types
   // **********************************************************************
   typedef logic [secure_width-1:0] policy_t;
   typedef logic [num_features-1:0] feature_vec_t;
   // bit 0 customer visa disable, bit 1 all visa disable
   // upper bits are the feature enables
   typedef logic [group_width-1:0]  group_t;

   // code held after reset, the most locked policy
   localparam policy_t policy_reset = '0;

   // register slave to plugin
   typedef struct packed {
      policy_t secure_policy;
      logic    policy_update;
      logic    earlyboot_exit;
      group_t  sb_ovr_value;
      policy_t oem_policy;
   } policy_in_t;

   // plugin outputs, same bit order as a matrix entry
   typedef struct packed {
      feature_vec_t feature_en;
      logic         visa_all_dis;
      logic         visa_customer_dis;
   } dfx_enable_t;

endpackage

/* dfx_secure/dfx_policy_regs.sv */
// wishbone classic register slave for the policy plugin
// holds the policy, boot flag, override value and oem strap, and reads
// back the plugin outputs through a status register
`timescale 1ns/1ps

module dfx_policy_regs
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  dfx_bus_pkg::wb_req_t        wb_req,
   output dfx_bus_pkg::wb_rsp_t        wb_rsp,
   input  dfx_policy_pkg::dfx_enable_t enables,
   input  dfx_policy_pkg::policy_t     captured_policy,
   output dfx_policy_pkg::policy_in_t  policy_in
);

   // **********************************************************************
   // internal signals
   // **********************************************************************
   logic                   ack_q;
   logic                   access;
   logic                   wr_en;
   logic                   update_q;
   logic                   boot_q;
   dfx_policy_pkg::policy_t policy_q;
   dfx_policy_pkg::group_t  sb_ovr_q;
   dfx_policy_pkg::policy_t oem_q;
   dfx_bus_pkg::wb_data_t   rd_data;

   // new cycle seen while ack is still low
   assign access = wb_req.cyc && wb_req.stb && !ack_q;
   assign wr_en  = access && wb_req.we;

   // **********************************************************************
   // handshake and register writes
   // **********************************************************************
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ack_q    <= 1'b0;
         update_q <= 1'b0;
         boot_q   <= 1'b0;
         policy_q <= dfx_policy_pkg::policy_reset;
         sb_ovr_q <= '0;
         oem_q    <= '0;
      end
      else
      begin
         // one cycle ack for every access including unmapped ones
         ack_q    <= access;
         // strobe rises with ack so the plugin loads on the next edge
         update_q <= wr_en && (wb_req.adr == dfx_bus_pkg::reg_policy);
         if (wr_en)
         begin
            case (wb_req.adr)
               dfx_bus_pkg::reg_policy:
               begin
                  policy_q <= wb_req.dat_w[3:0];
               end
               dfx_bus_pkg::reg_boot:
               begin
                  // sticky bit that a zero write leaves set
                  boot_q <= boot_q | wb_req.dat_w[0];
               end
               dfx_bus_pkg::reg_sb_ovr:
               begin
                  sb_ovr_q <= wb_req.dat_w[9:0];
               end
               dfx_bus_pkg::reg_oem:
               begin
                  oem_q <= wb_req.dat_w[3:0];
               end
               default:
               begin
                  // status and unmapped writes are dropped
               end
            endcase
         end
      end
   end

   // **********************************************************************
   // read back
   // **********************************************************************
   // read mux follows the adr that the master holds through ack
   always_comb
   begin
      case (wb_req.adr)
         dfx_bus_pkg::reg_policy: rd_data = {12'h000, policy_q};
         dfx_bus_pkg::reg_boot:   rd_data = {15'h0000, boot_q};
         dfx_bus_pkg::reg_sb_ovr: rd_data = {6'h00, sb_ovr_q};
         dfx_bus_pkg::reg_oem:    rd_data = {12'h000, oem_q};
         dfx_bus_pkg::reg_status: rd_data = {captured_policy, 2'b00, enables};
         default:                 rd_data = '0;
      endcase
   end

   assign wb_rsp.ack   = ack_q;
   // data only valid during ack
   assign wb_rsp.dat_r = ack_q ? rd_data : '0;

   // plugin inputs
   assign policy_in.secure_policy  = policy_q;
   assign policy_in.policy_update  = update_q;
   assign policy_in.earlyboot_exit = boot_q;
   assign policy_in.sb_ovr_value   = sb_ovr_q;
   assign policy_in.oem_policy     = oem_q;

   // read data in the ack cycle belongs to the address of the request
   a_adr_held : assert property (
      @(posedge clk) disable iff (!rst_n)
      access |=> $stable(wb_req.adr))
      else $error("master changed the address before the ack cycle ended");

endmodule

/* dfx_secure/dfx_secure_plugin.sv */
// debug security plugin
// captures the chip policy and maps it through a constant matrix into
// debug feature enables and visa controls
`timescale 1ns/1ps

module dfx_secure_plugin #(
   // 16 entries of group_width bits with entry n at bit n*group_width
   parameter logic [dfx_policy_pkg::matrix_width-1:0] policy_matrix = '0,
   // enable set while the early boot window is open
   parameter dfx_policy_pkg::group_t earlyboot_enable = '0,
   // allow the sideband override for the oem policy
   parameter bit use_sb_ovr = 1'b0
)
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  dfx_policy_pkg::policy_in_t  policy_in,
   output dfx_policy_pkg::dfx_enable_t enables,
   output dfx_policy_pkg::policy_t     captured_policy
);

   // **********************************************************************
   // internal signals
   // **********************************************************************
   // matrix split into one entry per code
   dfx_policy_pkg::group_t matrix_tbl [dfx_policy_pkg::num_policies];
   dfx_policy_pkg::group_t matrix_entry;
   dfx_policy_pkg::group_t group_mux;
   logic                   oem_match;

   // **********************************************************************
   // policy capture
   // **********************************************************************
   // policy flop loaded only by the update strobe
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         captured_policy <= dfx_policy_pkg::policy_reset;
      end
      else if (policy_in.policy_update)
      begin
         captured_policy <= policy_in.secure_policy;
      end
   end

   // **********************************************************************
   // matrix lookup
   // **********************************************************************
   for (genvar n = 0; n < dfx_policy_pkg::num_policies; n++)
   begin : g_tbl
      assign matrix_tbl[n] =
         policy_matrix[n*dfx_policy_pkg::group_width +: dfx_policy_pkg::group_width];
   end

   assign matrix_entry = matrix_tbl[captured_policy];

   // sideband override only applies to the oem policy code
   assign oem_match = use_sb_ovr && (captured_policy == policy_in.oem_policy);
   assign group_mux = oem_match ? policy_in.sb_ovr_value : matrix_entry;

   // early boot set wins until the boot window closes
   // entry and output share the same bit order
   assign enables = policy_in.earlyboot_exit ? group_mux : earlyboot_enable;

   // **********************************************************************
   // assertions
   // **********************************************************************
   // the register slave must give a single cycle update strobe
   a_update_pulse : assert property (
      @(posedge clk) disable iff (!rst_n)
      policy_in.policy_update |=> !policy_in.policy_update)
      else $error("policy update held high for more than one cycle");

   // once early boot closes it stays closed until reset
   a_earlyboot : assert property (
      @(posedge clk) disable iff (!rst_n)
      policy_in.earlyboot_exit |=> policy_in.earlyboot_exit)
      else $error("early boot exit cleared without a reset");

endmodule

/* logic/dfx_secure_top.sv */
// debug security block top level
// connects the wishbone register slave to the policy plugin and sets
// the policy matrix for this ip
`timescale 1ns/1ps

module dfx_secure_top #(
   // sample matrix, entry 15 first down to entry 0
   parameter logic [dfx_policy_pkg::matrix_width-1:0] policy_matrix = {
      10'h003,  // 15 part disabled, all visa off
      10'h3f8, 10'h3e8, 10'h1d8, 10'h0f8, 10'h0e8, 10'h0d8, 10'h0c8,
      10'h0b8,  // 7
      10'h0aa,  // 6
      10'h1fc,  // 5 oem unlocked
      10'h3fc,  // 4 fully unlocked
      10'h004,  // 3 fuse programming only
      10'h0fe,  // 2
      10'h01b,  // 1
      10'h003   // 0 security locked
   },
   // every feature on and visa open during early boot
   parameter dfx_policy_pkg::group_t earlyboot_enable = 10'h3fc,
   parameter bit use_sb_ovr = 1'b0
)
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  dfx_bus_pkg::wb_req_t        wb_req,
   output dfx_bus_pkg::wb_rsp_t        wb_rsp,
   output dfx_policy_pkg::dfx_enable_t dfx_en
);

   dfx_policy_pkg::policy_in_t policy_in;
   dfx_policy_pkg::policy_t    captured_policy;

   // register slave, also reads back the plugin outputs
   dfx_policy_regs u_regs (
      .clk             (clk),
      .rst_n           (rst_n),
      .wb_req          (wb_req),
      .wb_rsp          (wb_rsp),
      .enables         (dfx_en),
      .captured_policy (captured_policy),
      .policy_in       (policy_in)
   );

   // policy capture and lookup
   dfx_secure_plugin #(
      .policy_matrix    (policy_matrix),
      .earlyboot_enable (earlyboot_enable),
      .use_sb_ovr       (use_sb_ovr)
   ) u_plugin (
      .clk             (clk),
      .rst_n           (rst_n),
      .policy_in       (policy_in),
      .enables         (dfx_en),
      .captured_policy (captured_policy)
   );

endmodule

/* verification/dfx_secure_tb.sv */
// testbench for the debug security block
// drives the wishbone register slave and checks dfx_en and the status
// word against a reference model of the policy rule
`timescale 1ns/1ps

module dfx_secure_tb;

   // **********************************************************************
   // matrix and early boot set with every entry different
   // **********************************************************************
   localparam logic [159:0] tb_matrix = {
      10'h3c3, 10'h38c, 10'h351, 10'h31e, 10'h2e7, 10'h2b8, 10'h27d, 10'h242,
      10'h20b, 10'h1d4, 10'h199, 10'h166, 10'h12f, 10'h0f0, 10'h0b5, 10'h07a
   };
   localparam dfx_policy_pkg::group_t tb_boot_en = 10'h2a5;

   logic                        clk;
   logic                        rst_n;
   dfx_bus_pkg::wb_req_t        wb_req;
   dfx_bus_pkg::wb_rsp_t        wb_rsp;
   dfx_policy_pkg::dfx_enable_t dfx_en;

   // model of the register contents
   dfx_policy_pkg::policy_t m_policy;
   logic                    m_boot;
   dfx_policy_pkg::group_t  m_ovr;
   dfx_policy_pkg::policy_t m_oem;

   // one pending check compared on the next falling edge
   string                 chk_name;
   dfx_bus_pkg::wb_data_t chk_exp;
   dfx_bus_pkg::wb_data_t chk_act;
   bit                    chk_use_en;
   int unsigned           chk_cycle = '1;
   int unsigned           cyc_cnt = 0;

   int     checks = 0;
   int     errors = 0;
   int     timeouts = 0;
   integer seed = 24418;

   dfx_secure_top #(
      .policy_matrix    (tb_matrix),
      .earlyboot_enable (tb_boot_en),
      .use_sb_ovr       (1'b1)
   ) UUT (
      .clk    (clk),
      .rst_n  (rst_n),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp),
      .dfx_en (dfx_en)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cyc_cnt <= cyc_cnt + 1;
   end

   // **********************************************************************
   // reference model and checks
   // **********************************************************************
   // early boot set first, then oem override, then the matrix entry
   function automatic dfx_policy_pkg::group_t expected_en(
      input dfx_policy_pkg::policy_t pol,
      input logic                    boot,
      input dfx_policy_pkg::group_t  ovr,
      input dfx_policy_pkg::policy_t oem);
      int base;
      base = int'(pol) * 10;
      if (!boot)
         return tb_boot_en;
      if (pol == oem)
         return ovr;
      return tb_matrix[base +: 10];
   endfunction

   task automatic check_val(input string name, input dfx_bus_pkg::wb_data_t exp,
                            input dfx_bus_pkg::wb_data_t act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
      end
   endtask

   // compare process fires once per posted check
   always @(negedge clk)
   begin
      if (cyc_cnt == chk_cycle)
      begin
         if (chk_use_en)
            check_val(chk_name, chk_exp, {6'h00, dfx_en});
         else
            check_val(chk_name, chk_exp, chk_act);
      end
   end

   // posted on a falling edge and compared one cycle later
   task automatic post_check(input string name, input dfx_bus_pkg::wb_data_t exp,
                             input dfx_bus_pkg::wb_data_t act, input bit use_en);
      chk_name   = name;
      chk_exp    = exp;
      chk_act    = act;
      chk_use_en = use_en;
      chk_cycle  = cyc_cnt + 1;
   endtask

   // register write rules where the boot bit only ever sets
   task automatic update_model(input dfx_bus_pkg::wb_addr_t adr,
                               input dfx_bus_pkg::wb_data_t dat);
      case (adr)
         dfx_bus_pkg::reg_policy: m_policy = dat[3:0];
         dfx_bus_pkg::reg_boot:   m_boot = m_boot | dat[0];
         dfx_bus_pkg::reg_sb_ovr: m_ovr = dat[9:0];
         dfx_bus_pkg::reg_oem:    m_oem = dat[3:0];
         default:                 m_boot = m_boot;
      endcase
   endtask

   // **********************************************************************
   // wishbone master
   // **********************************************************************
   task automatic wb_write(input dfx_bus_pkg::wb_addr_t adr,
                           input dfx_bus_pkg::wb_data_t dat, input string name);
      int i;
      bit got;
      got = 1'b0;
      i = 0;
      update_model(adr, dat);
      @(negedge clk);
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = 1'b1;
      wb_req.adr   = adr;
      wb_req.dat_w = dat;
      while (!got && i < 20)
      begin
         @(negedge clk);
         got = wb_rsp.ack;
         i++;
      end
      if (got)
         post_check(name, {6'h00, expected_en(m_policy, m_boot, m_ovr, m_oem)},
                    16'h0000, 1'b1);
      else
      begin
         timeouts++;
         $display("write to address %0d got no ack within 20 cycles", adr);
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic wb_read(input dfx_bus_pkg::wb_addr_t adr,
                          output dfx_bus_pkg::wb_data_t dat);
      int i;
      bit got;
      got = 1'b0;
      i = 0;
      dat = '0;
      @(negedge clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b0;
      wb_req.adr = adr;
      while (!got && i < 20)
      begin
         @(negedge clk);
         got = wb_rsp.ack;
         i++;
      end
      // read data only valid while ack is high
      if (got)
         dat = wb_rsp.dat_r;
      else
      begin
         timeouts++;
         $display("read from address %0d got no ack within 20 cycles", adr);
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
   endtask

   // **********************************************************************
   // test sequence
   // **********************************************************************
   initial
   begin
      dfx_bus_pkg::wb_data_t rd;
      logic [31:0]           r;
      int                    order [16];
      int                    j;
      int                    tmp;
      wb_req   = '0;
      rst_n    = 1'b0;
      m_policy = '0;
      m_boot   = 1'b0;
      m_ovr    = '0;
      m_oem    = '0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;

      // out of reset the early boot set drives the outputs
      post_check("reset_en", {6'h00, tb_boot_en}, 16'h0000, 1'b1);
      wb_read(dfx_bus_pkg::reg_status, rd);
      post_check("reset_status", {4'h0, 2'b00, tb_boot_en}, rd, 1'b0);

      // policy is captured but hidden while boot is open
      wb_write(dfx_bus_pkg::reg_policy, 16'h0009, "boot_open_en");
      wb_read(dfx_bus_pkg::reg_status, rd);
      post_check("boot_open_status", {4'h9, 2'b00, tb_boot_en}, rd, 1'b0);

      wb_write(dfx_bus_pkg::reg_boot, 16'h0001, "boot_exit");
      for (int i = 0; i < 16; i++)
         order[i] = i;
      for (int i = 15; i > 0; i--)
      begin
         r = $random(seed);
         j = int'(r[3:0]) % (i + 1);
         tmp = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      // oem strap kept off the code under test so each code shows its own entry
      for (int i = 0; i < 16; i++)
      begin
         wb_write(dfx_bus_pkg::reg_oem, 16'(15 - order[i]), "matrix_oem");
         wb_write(dfx_bus_pkg::reg_policy, 16'(order[i]), "matrix_en");
         wb_read(dfx_bus_pkg::reg_status, rd);
         post_check("matrix_status",
                    {m_policy, 2'b00, expected_en(m_policy, m_boot, m_ovr, m_oem)},
                    rd, 1'b0);
      end

      // a zero write keeps the boot bit
      wb_write(dfx_bus_pkg::reg_boot, 16'h0000, "boot_sticky_en");
      wb_read(dfx_bus_pkg::reg_boot, rd);
      post_check("boot_sticky_reg", 16'h0001, rd, 1'b0);

      // sideband override for the oem code
      r = $random(seed);
      wb_write(dfx_bus_pkg::reg_oem, 16'h0005, "oem_5");
      wb_write(dfx_bus_pkg::reg_sb_ovr, {6'h00, r[9:0]}, "ovr_random");
      wb_write(dfx_bus_pkg::reg_policy, 16'h0005, "ovr_policy_5");
      wb_write(dfx_bus_pkg::reg_policy, 16'h0006, "ovr_policy_6");
      wb_write(dfx_bus_pkg::reg_oem, 16'h0006, "ovr_oem_6");

      // unmapped address acks with zero
      wb_read(4'hb, rd);
      post_check("unmapped_read", 16'h0000, rd, 1'b0);

      // random register traffic including unmapped writes
      for (int k = 0; k < 40; k++)
      begin
         r = $random(seed);
         wb_write({1'b0, r[2:0]}, r[31:16], "random_seq");
      end

      repeat (3) @(negedge clk);
      $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

/* verilog.f */
common/dfx_policy_pkg.sv
common/dfx_bus_pkg.sv
dfx_secure/dfx_secure_plugin.sv
dfx_secure/dfx_policy_regs.sv
logic/dfx_secure_top.sv
verification/dfx_secure_tb.sv
